// File: source/wb_defs.svh
`ifndef WB_DEFS_SVH
`define WB_DEFS_SVH

// result slots carried by one packet.
`define WB_NUM_RES    4
`define WB_DATA_W     32
`define WB_ADDR_W     32
`define WB_NUM_GPR    8
`define WB_NUM_SEG    6
`define WB_SEG_W      16
`define WB_FLAGS_W    18
`define WB_IDX_W      4
`define WB_IE_TYPE_W  4
`define WB_SIZE_W     2

// ressize encodings.
`define WB_SIZE_BYTE  2'd0
`define WB_SIZE_WORD  2'd1
`define WB_SIZE_DWORD 2'd2

`endif

// File: source/wb_pkg.sv
`include "wb_defs.svh"

package wb_pkg;

    // register view of a destination word.
    typedef struct packed {
        logic [`WB_ADDR_W-`WB_IDX_W-1:0] unused;
        logic [`WB_IDX_W-1:0]            idx;
    } reg_dest_t;

    // memory results read the word as a byte address.
    typedef union packed {
        logic [`WB_ADDR_W-1:0] addr;
        reg_dest_t             reg_dst;
    } res_dest_u;

    typedef struct packed {
        logic                  we;
        logic                  is_reg;
        logic                  is_seg;
        logic                  is_mem;
        logic [`WB_DATA_W-1:0] value;
        res_dest_u             dest;
    } wb_slot_t;

    typedef struct packed {
        logic [`WB_ADDR_W-1:0]                eip;
        logic                                 ie;
        logic [`WB_IE_TYPE_W-1:0]             ie_type;
        logic [`WB_FLAGS_W-1:0]               eflags;
        logic                                 eflags_we;
        logic [`WB_SIZE_W-1:0]                ressize;
        logic                                 br_valid;
        logic                                 br_taken;
        logic                                 br_correct;
        logic [`WB_ADDR_W-1:0]                br_fip;
        logic [`WB_ADDR_W-1:0]                br_fip_p1;
        wb_slot_t [`WB_NUM_RES-1:0]           slots;
    } wb_packet_t;

    typedef struct packed {
        logic [`WB_ADDR_W-1:0] addr;
        logic [`WB_DATA_W-1:0] data;
        logic [`WB_SIZE_W-1:0] ressize;
    } store_t;

    typedef struct packed {
        logic                  valid;
        logic                  is_seg;
        logic [`WB_IDX_W-1:0]  idx;
        logic [`WB_DATA_W-1:0] data;
        logic [`WB_SIZE_W-1:0] ressize;
    } reg_write_t;

endpackage

// File: source/ex_wb_latch.sv
`timescale 1ns/1ps

module ex_wb_latch (
    input  logic               clk,
    input  logic               reset,
    input  logic               in_valid,
    input  wb_pkg::wb_packet_t in_packet,
    output logic               in_ready,
    input  logic               done,
    input  logic               squash,
    output logic               held_valid,
    output wb_pkg::wb_packet_t held_packet
);

    logic load;

    // free when empty or when the held packet leaves this edge.
    assign in_ready = ~held_valid | done;
    assign load = in_ready & in_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            held_valid <= 1'b0;
        end else if (in_ready) begin
            // younger packet is dropped on a squash edge.
            held_valid <= in_valid & ~squash;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            held_packet <= in_packet; // payload only.
        end
    end

endmodule

// File: source/wb_commit.sv
`timescale 1ns/1ps

`include "wb_defs.svh"

module wb_commit (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  held_valid,
    input  wb_pkg::wb_packet_t                    held_packet,
    output logic                                  done,
    output logic                                  squash,
    output logic                                  store_valid,
    output wb_pkg::store_t                        store,
    input  logic                                  store_ready,
    output wb_pkg::reg_write_t [`WB_NUM_RES-1:0]  reg_writes,
    output logic                                  flags_we,
    output logic [`WB_FLAGS_W-1:0]                flags,
    output logic                                  redirect_valid,
    output logic [`WB_ADDR_W-1:0]                 redirect_target,
    output logic                                  exc_valid,
    output logic [`WB_IE_TYPE_W-1:0]              exc_type,
    output logic [`WB_ADDR_W-1:0]                 exc_eip
);

    import wb_pkg::*;

    localparam int PTR_W = $clog2(`WB_NUM_RES);

    logic [PTR_W-1:0]       ptr;
    logic [PTR_W-1:0]       cur;
    logic [`WB_NUM_RES-1:0] pending;
    logic [`WB_NUM_RES-1:0] rest;
    logic                   more;
    logic                   store_fire;
    logic                   retire_ok;
    wb_slot_t               cur_slot;

    // memory slots not yet sent, and the lowest of them.
    always_comb begin
        pending = '0;
        cur = '0;
        for (int i = `WB_NUM_RES - 1; i >= 0; i--) begin
            pending[i] = held_packet.slots[i].we && held_packet.slots[i].is_mem
                         && (PTR_W'(i) >= ptr);
            if (pending[i]) begin
                cur = PTR_W'(i);
            end
        end
        rest = pending;
        rest[cur] = 1'b0;
        more = |rest;
    end

    assign cur_slot = held_packet.slots[cur];

    // an excepting packet sends nothing.
    assign store_valid = held_valid & ~held_packet.ie & (|pending);
    assign store_fire = store_valid & store_ready;

    always_comb begin
        store.addr = cur_slot.dest.addr; // address view.
        store.data = cur_slot.value;
        store.ressize = held_packet.ressize;
    end

    // retire with no stores left, or on the last store transfer.
    assign done = held_valid
                  & (held_packet.ie | ~(|pending) | (store_fire & ~more));
    assign retire_ok = done & ~held_packet.ie;

    always_ff @(posedge clk) begin
        if (reset || done) begin
            ptr <= '0;
        end else if (store_fire) begin
            ptr <= cur + 1'b1; // skip past the slot just sent.
        end
    end

    always_comb begin
        for (int i = 0; i < `WB_NUM_RES; i++) begin
            reg_writes[i].valid = retire_ok && held_packet.slots[i].we
                                  && (held_packet.slots[i].is_reg
                                      || held_packet.slots[i].is_seg);
            reg_writes[i].is_seg = held_packet.slots[i].is_seg;
            reg_writes[i].idx = held_packet.slots[i].dest.reg_dst.idx; // index view.
            reg_writes[i].data = held_packet.slots[i].value;
            reg_writes[i].ressize = held_packet.ressize;
        end
    end

    assign flags_we = retire_ok & held_packet.eflags_we;
    assign flags = held_packet.eflags;

    // mispredict resolves to the path actually taken.
    assign redirect_valid = retire_ok & held_packet.br_valid & ~held_packet.br_correct;
    assign redirect_target = held_packet.br_taken ? held_packet.br_fip
                                                  : held_packet.br_fip_p1;

    assign exc_valid = done & held_packet.ie;
    assign exc_type = held_packet.ie_type;
    assign exc_eip = held_packet.eip;

    assign squash = redirect_valid | exc_valid;

endmodule

// File: source/arch_regs.sv
`timescale 1ns/1ps

`include "wb_defs.svh"

module arch_regs (
    input  logic                                  clk,
    input  logic                                  reset,
    input  wb_pkg::reg_write_t [`WB_NUM_RES-1:0]  reg_writes,
    input  logic                                  flags_we,
    input  logic [`WB_FLAGS_W-1:0]                flags_in,
    input  logic [`WB_IDX_W-1:0]                  rd_sel,
    output logic [`WB_DATA_W-1:0]                 rd_data,
    output logic [`WB_FLAGS_W-1:0]                eflags
);

    logic [`WB_DATA_W-1:0] gpr [`WB_NUM_GPR];
    logic [`WB_SEG_W-1:0]  seg [`WB_NUM_SEG];

    // slots in order, so a later write to the same register wins.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < `WB_NUM_GPR; r++) begin
                gpr[r] <= '0;
            end
            for (int s = 0; s < `WB_NUM_SEG; s++) begin
                seg[s] <= '0;
            end
            eflags <= '0;
        end else begin
            for (int i = 0; i < `WB_NUM_RES; i++) begin
                if (reg_writes[i].valid) begin
                    if (reg_writes[i].is_seg) begin
                        if (reg_writes[i].idx < `WB_NUM_SEG) begin
                            seg[reg_writes[i].idx[2:0]] <= reg_writes[i].data[`WB_SEG_W-1:0];
                        end
                    end else if (reg_writes[i].idx < `WB_NUM_GPR) begin
                        case (reg_writes[i].ressize)
                            `WB_SIZE_BYTE: begin
                                gpr[reg_writes[i].idx[2:0]][7:0] <= reg_writes[i].data[7:0];
                            end
                            `WB_SIZE_WORD: begin
                                gpr[reg_writes[i].idx[2:0]][15:0] <= reg_writes[i].data[15:0];
                            end
                            default: begin
                                gpr[reg_writes[i].idx[2:0]] <= reg_writes[i].data;
                            end
                        endcase
                    end
                end
            end
            if (flags_we) begin
                eflags <= flags_in;
            end
        end
    end

    // 0-7 general, 8-13 segment.
    always_comb begin
        rd_data = '0;
        if (!rd_sel[3]) begin
            rd_data = gpr[rd_sel[2:0]];
        end else if (rd_sel[2:0] < `WB_NUM_SEG) begin
            rd_data = {{(`WB_DATA_W-`WB_SEG_W){1'b0}}, seg[rd_sel[2:0]]};
        end
    end

endmodule

// File: source/ex_wb_top.sv
`timescale 1ns/1ps

`include "wb_defs.svh"

module ex_wb_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     in_valid,
    input  wb_pkg::wb_packet_t       in_packet,
    output logic                     in_ready,
    output logic                     store_valid,
    output wb_pkg::store_t           store,
    input  logic                     store_ready,
    output logic                     redirect_valid,
    output logic [`WB_ADDR_W-1:0]    redirect_target,
    output logic                     exc_valid,
    output logic [`WB_IE_TYPE_W-1:0] exc_type,
    output logic [`WB_ADDR_W-1:0]    exc_eip,
    input  logic [`WB_IDX_W-1:0]     rd_sel,
    output logic [`WB_DATA_W-1:0]    rd_data,
    output logic [`WB_FLAGS_W-1:0]   eflags
);

    import wb_pkg::*;

    logic                              held_valid;
    wb_packet_t                        held_packet;
    logic                              done;
    logic                              squash;
    reg_write_t [`WB_NUM_RES-1:0]      reg_writes;
    logic                              flags_we;
    logic [`WB_FLAGS_W-1:0]            flags;

    ex_wb_latch latch0 (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_packet   (in_packet),
        .in_ready    (in_ready),
        .done        (done),
        .squash      (squash),
        .held_valid  (held_valid),
        .held_packet (held_packet)
    );

    wb_commit commit0 (
        .clk             (clk),
        .reset           (reset),
        .held_valid      (held_valid),
        .held_packet     (held_packet),
        .done            (done),
        .squash          (squash),
        .store_valid     (store_valid),
        .store           (store),
        .store_ready     (store_ready),
        .reg_writes      (reg_writes),
        .flags_we        (flags_we),
        .flags           (flags),
        .redirect_valid  (redirect_valid),
        .redirect_target (redirect_target),
        .exc_valid       (exc_valid),
        .exc_type        (exc_type),
        .exc_eip         (exc_eip)
    );

    arch_regs regs0 (
        .clk        (clk),
        .reset      (reset),
        .reg_writes (reg_writes),
        .flags_we   (flags_we),
        .flags_in   (flags),
        .rd_sel     (rd_sel),
        .rd_data    (rd_data),
        .eflags     (eflags)
    );

endmodule

// File: bench/wb_model.svh
// expected register state and queues.
wb_packet_t            held_q[$];
store_t                store_q[$];
logic [`WB_DATA_W-1:0] m_gpr [`WB_NUM_GPR];
logic [`WB_SEG_W-1:0]  m_seg [`WB_NUM_SEG];
logic [`WB_FLAGS_W-1:0] m_flags;

task automatic clear_expected();
    held_q.delete();
    store_q.delete();
    for (int r = 0; r < `WB_NUM_GPR; r++) begin
        m_gpr[r] = '0;
    end
    for (int s = 0; s < `WB_NUM_SEG; s++) begin
        m_seg[s] = '0;
    end
    m_flags = '0;
endtask

// the held packet, and its stores in slot order.
task automatic queue_packet(input wb_packet_t p);
    store_t s;
    held_q.push_back(p);
    if (!p.ie) begin
        for (int i = 0; i < `WB_NUM_RES; i++) begin
            if (p.slots[i].we && p.slots[i].is_mem) begin
                s.addr = p.slots[i].dest;
                s.data = p.slots[i].value;
                s.ressize = p.ressize;
                store_q.push_back(s);
            end
        end
    end
endtask

task automatic apply_retire(input wb_packet_t p);
    logic [3:0] idx;
    for (int i = 0; i < `WB_NUM_RES; i++) begin
        idx = p.slots[i].dest[3:0]; // low nibble is the index.
        if (p.slots[i].we && p.slots[i].is_seg) begin
            if (idx < 4'd6) begin
                m_seg[idx[2:0]] = p.slots[i].value[15:0];
            end
        end else if (p.slots[i].we && p.slots[i].is_reg && idx < 4'd8) begin
            case (p.ressize)
                2'd0: m_gpr[idx[2:0]][7:0] = p.slots[i].value[7:0];
                2'd1: m_gpr[idx[2:0]][15:0] = p.slots[i].value[15:0];
                default: m_gpr[idx[2:0]] = p.slots[i].value;
            endcase
        end
    end
    if (p.eflags_we) begin
        m_flags = p.eflags;
    end
endtask

// File: bench/tb_ex_wb.sv
`timescale 1ns/1ps

`include "wb_defs.svh"

module tb_ex_wb;

    import wb_pkg::*;

    localparam int PERIOD = 100;
    localparam int PKTS_PER_TEST = 60;
    localparam int TOTAL_PKTS = 3 * PKTS_PER_TEST;

    logic                     clk;
    logic                     reset;
    logic                     in_valid;
    wb_packet_t               in_packet;
    logic                     in_ready;
    logic                     store_valid;
    store_t                   store;
    logic                     store_ready;
    logic                     redirect_valid;
    logic [`WB_ADDR_W-1:0]    redirect_target;
    logic                     exc_valid;
    logic [`WB_IE_TYPE_W-1:0] exc_type;
    logic [`WB_ADDR_W-1:0]    exc_eip;
    logic [`WB_IDX_W-1:0]     rd_sel;
    logic [`WB_DATA_W-1:0]    rd_data;
    logic [`WB_FLAGS_W-1:0]   eflags;

    int   errors = 0;
    int   retired = 0;
    int   dropped = 0;
    int   stores_seen = 0;
    logic accepted = 1'b0;
    logic need_sweep = 1'b0;

    `include "wb_model.svh"

    ex_wb_top dut0 (
        .clk             (clk),
        .reset           (reset),
        .in_valid        (in_valid),
        .in_packet       (in_packet),
        .in_ready        (in_ready),
        .store_valid     (store_valid),
        .store           (store),
        .store_ready     (store_ready),
        .redirect_valid  (redirect_valid),
        .redirect_target (redirect_target),
        .exc_valid       (exc_valid),
        .exc_type        (exc_type),
        .exc_eip         (exc_eip),
        .rd_sel          (rd_sel),
        .rd_data         (rd_data),
        .eflags          (eflags)
    );

    always #(PERIOD / 2) clk = ~clk;

    task automatic mismatch(input string name, input logic [63:0] exp, input logic [63:0] got);
        $display("FAILED %s expected 0x%0h got 0x%0h", name, exp, got);
        errors++;
    endtask

    task automatic problem(input string what);
        $display("error: %s", what);
        errors++;
    endtask

    function automatic wb_packet_t random_packet(input int ie_pct, input int br_pct);
        wb_packet_t p;
        int         kind;
        p.eip = $urandom;
        p.ie = ($urandom % 100) < ie_pct;
        p.ie_type = 4'($urandom);
        p.eflags = 18'($urandom);
        p.eflags_we = 1'($urandom);
        p.ressize = 2'($urandom % 3);
        p.br_valid = ($urandom % 100) < br_pct;
        p.br_taken = 1'($urandom);
        p.br_correct = 1'($urandom);
        p.br_fip = $urandom;
        p.br_fip_p1 = $urandom;
        for (int i = 0; i < `WB_NUM_RES; i++) begin
            kind = $urandom % 3;
            p.slots[i].we = ($urandom % 5) != 0;
            p.slots[i].is_reg = (kind == 0);
            p.slots[i].is_seg = (kind == 1);
            p.slots[i].is_mem = (kind == 2);
            p.slots[i].value = $urandom;
            p.slots[i].dest = $urandom; // upper bits are noise for registers.
            if (kind == 0) begin
                p.slots[i].dest[3:0] = 4'($urandom % 8);
            end else if (kind == 1) begin
                p.slots[i].dest[3:0] = 4'($urandom % 6);
            end
        end
        return p;
    endfunction

    task automatic sweep_regs();
        logic [31:0] exp;
        for (int sel = 0; sel < 14; sel++) begin
            rd_sel = 4'(sel);
            #1;
            exp = (sel < 8) ? m_gpr[sel] : {16'h0, m_seg[sel - 8]};
            if (rd_data !== exp) begin
                mismatch($sformatf("rd_data[%0d]", sel), exp, rd_data);
            end
        end
        if (eflags !== m_flags) begin
            mismatch("eflags", m_flags, eflags);
        end
    endtask

    // outputs idle and state zero after a reset.
    task automatic reset_and_check(input string name);
        int err0;
        reset = 1'b1;
        in_valid = 1'b0;
        store_ready = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        clear_expected();
        err0 = errors;
        if (store_valid !== 1'b0) mismatch("store_valid", 0, store_valid);
        if (redirect_valid !== 1'b0) mismatch("redirect_valid", 0, redirect_valid);
        if (exc_valid !== 1'b0) mismatch("exc_valid", 0, exc_valid);
        if (in_ready !== 1'b1) mismatch("in_ready", 1, in_ready);
        sweep_regs();
        $display("test %s: %0d errors", name, errors - err0);
    endtask

    // per-edge comparison of the DUT against the model.
    task automatic check_edge();
        wb_packet_t h;
        store_t     s;
        logic       retire;
        logic       kill;
        logic       exp_redir;
        retire = 1'b0;
        kill = 1'b0;
        if (store_valid && store_q.size() == 0) begin
            problem("store_valid high with no store expected");
        end else if (!store_valid && store_q.size() > 0) begin
            problem("store_valid low with a store pending");
        end else if (store_valid && store_ready) begin
            s = store_q.pop_front();
            stores_seen++;
            if (store.addr !== s.addr) mismatch("store.addr", s.addr, store.addr);
            if (store.data !== s.data) mismatch("store.data", s.data, store.data);
            if (store.ressize !== s.ressize) mismatch("store.ressize", s.ressize, store.ressize);
        end
        if (held_q.size() > 0) begin
            h = held_q[0];
            retire = h.ie || store_q.size() == 0;
        end
        if (retire) begin
            exp_redir = !h.ie && h.br_valid && !h.br_correct;
            kill = h.ie || exp_redir;
            if (exc_valid !== h.ie) mismatch("exc_valid", h.ie, exc_valid);
            if (h.ie && exc_type !== h.ie_type) mismatch("exc_type", h.ie_type, exc_type);
            if (h.ie && exc_eip !== h.eip) mismatch("exc_eip", h.eip, exc_eip);
            if (redirect_valid !== exp_redir) begin
                mismatch("redirect_valid", exp_redir, redirect_valid);
            end else if (exp_redir) begin
                if (redirect_target !== (h.br_taken ? h.br_fip : h.br_fip_p1)) begin
                    mismatch("redirect_target", h.br_taken ? h.br_fip : h.br_fip_p1,
                             redirect_target);
                end
            end
            if (!h.ie) apply_retire(h);
            void'(held_q.pop_front());
            retired++;
            need_sweep = 1'b1;
        end else if (redirect_valid || exc_valid) begin
            problem("redirect or exception raised with no retire");
        end
        if (in_ready !== (held_q.size() == 0)) begin
            mismatch("in_ready", held_q.size() == 0, in_ready);
        end
        if (in_valid && in_ready) begin
            accepted = 1'b1;
            if (kill) begin
                dropped++; // younger packet squashed.
            end else begin
                queue_packet(in_packet);
            end
        end
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            check_edge();
        end
    end

    task automatic run_phase(input string name, input int count, input int ie_pct,
                             input int br_pct);
        int err0;
        int sent;
        err0 = errors;
        sent = 0;
        while (sent < count || in_valid || held_q.size() > 0) begin
            @(negedge clk);
            if (accepted) begin
                accepted = 1'b0;
                in_valid = 1'b0;
                sent++;
            end
            store_ready = ($urandom % 4) != 0;
            if (!in_valid && sent < count && ($urandom % 4) != 0) begin
                in_packet = random_packet(ie_pct, br_pct);
                in_valid = 1'b1;
            end
            if (need_sweep) begin
                need_sweep = 1'b0;
                sweep_regs();
            end
        end
        $display("test %s: %0d packets, %0d errors", name, sent, errors - err0);
    endtask

    initial begin
        #((TOTAL_PKTS * 40 + 40) * PERIOD);
        $display("watchdog: simulation did not finish in time");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h05a8_4a40));
        clk = 1'b0;
        in_packet = '0;
        rd_sel = '0;
        reset_and_check("reset");

        run_phase("reg_store_mix", PKTS_PER_TEST, 0, 10);
        run_phase("exceptions", PKTS_PER_TEST, 40, 10);
        run_phase("branches", PKTS_PER_TEST, 5, 60);

        @(negedge clk);
        reset_and_check("reset_after_traffic");

        $display("counts: %0d retired, %0d dropped, %0d stores, %0d errors",
                 retired, dropped, stores_seen, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+source
+incdir+bench
source/wb_pkg.sv
source/ex_wb_latch.sv
source/wb_commit.sv
source/arch_regs.sv
source/ex_wb_top.sv
bench/tb_ex_wb.sv

// File: run.sh
#!/bin/sh
# build and run the writeback testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f flist.f --top-module tb_ex_wb -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1
